// ==== compile.f ====
logic/cache_pkg.sv
logic/cache_ctrl.sv
logic/line_store.sv
logic/line_refill_axi.sv
logic/read_cache_top.sv
sim/axi_mem_model.sv
sim/read_cache_tb.sv

// ==== logic/cache_ctrl.sv ====
module cache_ctrl import cache_pkg::*; (
   input  logic                    clk,
   input  logic                    reset,
   input  cache_addr_t             araddr,
   input  logic                    arvalid,
   output logic                    arready,
   output logic [data_w-1:0]       rdata,
   output logic [1:0]              rresp,
   output logic                    rvalid,
   input  logic                    rready,
   output logic                    replace_valid,
   output logic [line_addr_w-1:0]  replace_addr,
   input  logic                    replace,
   output logic                    rd_en,
   output logic [store_addr_w-1:0] rd_addr,
   input  logic [data_w-1:0]       rd_data,
   output logic [index_w-1:0]      fill_index
);

   logic [2:0]              state;
   cache_addr_t             req;                           // address of the request in flight
   logic [tag_w-1:0]        tag_mem [0:(1<<index_w)-1];
   logic [(1<<index_w)-1:0] valid;
   logic                    hit;
   logic                    fill_done;

   assign hit       = valid[req.field.index] && (tag_mem[req.field.index] == req.field.tag);
   assign fill_done = (state == ctl_wait_fill) && !replace;   // replace fell, line is in

   // cpu read port
   assign arready = (state == ctl_idle);
   assign rvalid  = (state == ctl_respond);
   assign rresp   = axi_resp_okay;                         // backend errors are retried

   // refill request
   assign replace_valid = (state == ctl_miss_req);
   assign replace_addr  = req.line.addr;
   assign fill_index    = req.field.index;

   // the first read is the lookup, the second comes right after a fill
   assign rd_en   = (state == ctl_lookup) || fill_done;
   assign rd_addr = {req.field.index, req.field.word};

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state <= ctl_idle;
         valid <= '0;
      end else begin
         case (state)
            ctl_idle: begin
               if (arvalid) begin
                  state <= ctl_lookup;
               end
            end
            ctl_lookup: begin
               if (hit) begin
                  state <= ctl_reread;
               end else begin
                  state <= ctl_miss_req;
               end
            end
            ctl_miss_req: begin
               if (replace) begin                          // engine took the request
                  state <= ctl_wait_fill;
               end
            end
            ctl_wait_fill: begin
               if (fill_done) begin
                  state <= ctl_reread;
                  valid[req.field.index] <= 1'b1;
               end
            end
            ctl_reread: begin
               state <= ctl_respond;
            end
            ctl_respond: begin
               if (rready) begin
                  state <= ctl_idle;
               end
            end
            default: begin
               state <= ctl_idle;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (arvalid && arready) begin
         req <= araddr;
      end
      if (fill_done) begin
         tag_mem[req.field.index] <= req.field.tag;
      end
      if (state == ctl_reread) begin
         rdata <= rd_data;                                 // held through back-pressure
      end
   end

endmodule

// ==== logic/cache_pkg.sv ====
package cache_pkg;

   // cache geometry
   localparam int addr_w       = 16;  // cpu byte address
   localparam int data_w       = 32;  // cpu and backend word
   localparam int nbytes_w     = 2;   // byte offset in a word
   localparam int line2be_w    = 2;   // 4 words per line
   localparam int index_w      = 3;   // 8 lines
   localparam int tag_w        = addr_w - index_w - line2be_w - nbytes_w;
   localparam int line_addr_w  = tag_w + index_w;
   localparam int store_addr_w = index_w + line2be_w;

   // axi4 constants
   localparam int axi_len_w                = 8;
   localparam int axi_id_w                 = 4;
   localparam logic [axi_id_w-1:0] axi_id  = '0;
   localparam logic [1:0] axi_burst_incr   = 2'b01;
   localparam logic [1:0] axi_resp_okay    = 2'b00;
   localparam logic [3:0] axi_cache_attr   = 4'b0011;  // normal, bufferable

   // controller states
   localparam logic [2:0] ctl_idle      = 3'd0;
   localparam logic [2:0] ctl_lookup    = 3'd1;
   localparam logic [2:0] ctl_miss_req  = 3'd2;
   localparam logic [2:0] ctl_wait_fill = 3'd3;
   localparam logic [2:0] ctl_reread    = 3'd4;  // store data returns
   localparam logic [2:0] ctl_respond   = 3'd5;

   // refill engine states
   localparam logic [1:0] rf_idle = 2'd0;
   localparam logic [1:0] rf_addr = 2'd1;
   localparam logic [1:0] rf_load = 2'd2;
   localparam logic [1:0] rf_end  = 2'd3;

   typedef struct packed {
      logic [tag_w-1:0]     tag;
      logic [index_w-1:0]   index;
      logic [line2be_w-1:0] word;
      logic [nbytes_w-1:0]  byte_off;
   } addr_fields_t;

   typedef struct packed {
      logic [line_addr_w-1:0]        addr;    // tag and index
      logic [line2be_w+nbytes_w-1:0] offset;  // byte within the line
   } addr_line_t;

   // one cpu address, seen per field or per line
   typedef union packed {
      addr_fields_t field;
      addr_line_t   line;
   } cache_addr_t;

endpackage

// ==== logic/line_refill_axi.sv ====
module line_refill_axi import cache_pkg::*; (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   replace_valid,
   input  logic [line_addr_w-1:0] replace_addr,
   output logic                   replace,
   output logic                   write_en,
   output logic [line2be_w-1:0]   write_addr,
   output logic [data_w-1:0]      write_data,
   output logic [addr_w-1:0]      m_araddr,
   output logic [axi_id_w-1:0]    m_arid,
   output logic [axi_len_w-1:0]   m_arlen,
   output logic [2:0]             m_arsize,
   output logic [1:0]             m_arburst,
   output logic                   m_arlock,
   output logic [3:0]             m_arcache,
   output logic [2:0]             m_arprot,
   output logic [3:0]             m_arqos,
   output logic                   m_arvalid,
   input  logic                   m_arready,
   input  logic [data_w-1:0]      m_rdata,
   input  logic [1:0]             m_rresp,
   input  logic                   m_rlast,
   input  logic                   m_rvalid,
   output logic                   m_rready
);

   logic [1:0]  state;
   logic        slave_err;                                 // sticky over the whole burst
   cache_addr_t base;

   // burst base from the line view
   always_comb begin
      base.line.addr   = replace_addr;
      base.line.offset = '0;
   end

   // fixed burst form, one full line per burst
   assign m_araddr  = base;
   assign m_arid    = axi_id;
   assign m_arlen   = axi_len_w'((1 << line2be_w) - 1);
   assign m_arsize  = 3'(nbytes_w);
   assign m_arburst = axi_burst_incr;
   assign m_arlock  = 1'b0;
   assign m_arcache = axi_cache_attr;
   assign m_arprot  = 3'd0;
   assign m_arqos   = 4'd0;

   assign m_arvalid = (state == rf_addr);
   assign m_rready  = (state == rf_load);
   assign replace   = (state != rf_idle);

   // beats go straight into the line store
   assign write_en   = m_rvalid && m_rready;
   assign write_data = m_rdata;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state      <= rf_idle;
         write_addr <= '0;
         slave_err  <= 1'b0;
      end else begin
         case (state)
            rf_idle: begin
               if (replace_valid) begin
                  state <= rf_addr;
               end
            end
            rf_addr: begin
               write_addr <= '0;
               slave_err  <= 1'b0;
               if (m_arready) begin
                  state <= rf_load;
               end
            end
            rf_load: begin
               if (m_rvalid) begin
                  if (m_rresp != axi_resp_okay) begin
                     slave_err <= 1'b1;                    // burst runs to rlast anyway
                  end
                  if (m_rlast) begin
                     state <= rf_end;
                  end else begin
                     write_addr <= write_addr + 1'b1;
                  end
               end
            end
            default: begin
               // whole line again if any beat failed
               if (slave_err) begin
                  state <= rf_addr;
               end else begin
                  state <= rf_idle;
               end
            end
         endcase
      end
   end

endmodule

// ==== logic/line_store.sv ====
module line_store import cache_pkg::*; (
   input  logic                    clk,
   input  logic                    write_en,
   input  logic [line2be_w-1:0]    write_addr,
   input  logic [data_w-1:0]       write_data,
   input  logic [index_w-1:0]      fill_index,
   input  logic                    rd_en,
   input  logic [store_addr_w-1:0] rd_addr,
   output logic [data_w-1:0]       rd_data
);

   logic [data_w-1:0]       mem [0:(1<<store_addr_w)-1];
   logic [store_addr_w-1:0] wr_addr;

   // line being filled, word from the beat counter
   assign wr_addr = {fill_index, write_addr};

   always_ff @(posedge clk) begin
      if (write_en) begin
         mem[wr_addr] <= write_data;
      end
   end

   // registered read, data one cycle after rd_en
   always_ff @(posedge clk) begin
      if (rd_en) begin
         rd_data <= mem[rd_addr];
      end
   end

endmodule

// ==== logic/read_cache_top.sv ====
module read_cache_top import cache_pkg::*; (
   input  logic                 clk,
   input  logic                 reset,
   // cpu axi4-lite read port
   input  logic [addr_w-1:0]    araddr,
   input  logic                 arvalid,
   output logic                 arready,
   output logic [data_w-1:0]    rdata,
   output logic [1:0]           rresp,
   output logic                 rvalid,
   input  logic                 rready,
   // backing memory axi4 read port
   output logic [addr_w-1:0]    m_araddr,
   output logic [axi_id_w-1:0]  m_arid,
   output logic [axi_len_w-1:0] m_arlen,
   output logic [2:0]           m_arsize,
   output logic [1:0]           m_arburst,
   output logic                 m_arlock,
   output logic [3:0]           m_arcache,
   output logic [2:0]           m_arprot,
   output logic [3:0]           m_arqos,
   output logic                 m_arvalid,
   input  logic                 m_arready,
   input  logic [data_w-1:0]    m_rdata,
   input  logic [1:0]           m_rresp,
   input  logic                 m_rlast,
   input  logic                 m_rvalid,
   output logic                 m_rready
);

   logic                    replace_valid;
   logic [line_addr_w-1:0]  replace_addr;
   logic                    replace;
   logic                    write_en;
   logic [line2be_w-1:0]    write_addr;
   logic [data_w-1:0]       write_data;
   logic [index_w-1:0]      fill_index;
   logic                    rd_en;
   logic [store_addr_w-1:0] rd_addr;
   logic [data_w-1:0]       rd_data;

   cache_ctrl i_ctrl (
      .clk           (clk),
      .reset         (reset),
      .araddr        (araddr),
      .arvalid       (arvalid),
      .arready       (arready),
      .rdata         (rdata),
      .rresp         (rresp),
      .rvalid        (rvalid),
      .rready        (rready),
      .replace_valid (replace_valid),
      .replace_addr  (replace_addr),
      .replace       (replace),
      .rd_en         (rd_en),
      .rd_addr       (rd_addr),
      .rd_data       (rd_data),
      .fill_index    (fill_index)
   );

   line_store i_store (
      .clk        (clk),
      .write_en   (write_en),
      .write_addr (write_addr),
      .write_data (write_data),
      .fill_index (fill_index),
      .rd_en      (rd_en),
      .rd_addr    (rd_addr),
      .rd_data    (rd_data)
   );

   line_refill_axi i_refill (
      .clk           (clk),
      .reset         (reset),
      .replace_valid (replace_valid),
      .replace_addr  (replace_addr),
      .replace       (replace),
      .write_en      (write_en),
      .write_addr    (write_addr),
      .write_data    (write_data),
      .m_araddr      (m_araddr),
      .m_arid        (m_arid),
      .m_arlen       (m_arlen),
      .m_arsize      (m_arsize),
      .m_arburst     (m_arburst),
      .m_arlock      (m_arlock),
      .m_arcache     (m_arcache),
      .m_arprot      (m_arprot),
      .m_arqos       (m_arqos),
      .m_arvalid     (m_arvalid),
      .m_arready     (m_arready),
      .m_rdata       (m_rdata),
      .m_rresp       (m_rresp),
      .m_rlast       (m_rlast),
      .m_rvalid      (m_rvalid),
      .m_rready      (m_rready)
   );

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the read cache testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module read_cache_tb -f compile.f -o read_cache_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

output=$(./obj_dir/read_cache_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -qx "test passed"; then
   exit 0
fi
exit 1

// ==== sim/axi_mem_model.sv ====
module axi_mem_model import cache_pkg::*; #(
   parameter logic [line_addr_w-1:0] err_line = '0,
   parameter logic [31:0]            seed     = 32'd3
) (
   input  logic                 clk,
   input  logic                 reset,
   input  logic [addr_w-1:0]    araddr,
   input  logic [axi_len_w-1:0] arlen,
   input  logic                 arvalid,
   output logic                 arready,
   output logic [data_w-1:0]    rdata,
   output logic [1:0]           rresp,
   output logic                 rlast,
   output logic                 rvalid,
   input  logic                 rready,
   output int                   burst_count
);

   localparam logic [1:0] resp_okay   = 2'b00;
   localparam logic [1:0] resp_slverr = 2'b10;

   logic [31:0]          rng;
   logic                 busy;                             // a burst is being returned
   logic [addr_w-1:0]    base;
   logic [axi_len_w-1:0] len;
   logic [axi_len_w-1:0] beat;
   logic                 err_burst;
   logic                 err_done;                         // error already injected once
   logic [addr_w-3:0]    word_addr;

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   // data rule: word address xor a fixed pattern
   assign word_addr = base[addr_w-1:2] + (addr_w-2)'(beat);
   assign rdata     = data_w'(word_addr) ^ 32'h5a5a0000;
   assign rresp     = (err_burst && beat == 8'd2) ? resp_slverr : resp_okay;
   assign rlast     = (beat == len);

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         rng         <= seed;
         arready     <= 1'b0;
         rvalid      <= 1'b0;
         busy        <= 1'b0;
         base        <= '0;
         len         <= '0;
         beat        <= '0;
         err_burst   <= 1'b0;
         err_done    <= 1'b0;
         burst_count <= 0;
      end else begin
         rng <= lcg_next(rng);
         if (!busy) begin
            if (arvalid && arready) begin
               busy        <= 1'b1;
               arready     <= 1'b0;
               base        <= araddr;
               len         <= arlen;
               beat        <= '0;
               burst_count <= burst_count + 1;
               if (araddr[addr_w-1:addr_w-line_addr_w] == err_line && !err_done) begin
                  err_burst <= 1'b1;
                  err_done  <= 1'b1;
               end else begin
                  err_burst <= 1'b0;
               end
            end else begin
               arready <= (rng[17:16] != 2'b00);           // ready 3 cycles out of 4
            end
         end else if (rvalid && rready) begin
            if (beat == len) begin
               busy   <= 1'b0;
               rvalid <= 1'b0;
            end else begin
               beat   <= beat + 1'b1;
               rvalid <= (rng[19:18] != 2'b00);
            end
         end else if (!rvalid) begin
            rvalid <= (rng[19:18] != 2'b00);               // once high it holds until taken
         end
      end
   end

endmodule

// ==== sim/read_cache_tb.sv ====
module read_cache_tb import cache_pkg::*; ();

   localparam int                     n_rows         = 12;
   localparam int                     timeout_cycles = n_rows * 200;
   localparam logic [line_addr_w-1:0] err_line_addr  = 12'h0a3;

   // address, rready stall cycles, new bursts expected
   localparam logic [addr_w-1:0] row_addr [n_rows] = '{
      16'h0104, 16'h010c, 16'h0308, 16'h0100, 16'h0104, 16'h0a34,
      16'h0a38, 16'h1fe0, 16'h1fec, 16'h0a30, 16'h2234, 16'h0a3c};
   localparam int row_stall [n_rows] = '{0, 0, 2, 0, 5, 0, 3, 1, 0, 0, 0, 0};
   localparam int row_bursts [n_rows] = '{1, 0, 1, 1, 0, 2, 0, 1, 0, 0, 1, 1};

   logic                 clk = 1'b0;
   logic                 reset;
   logic [addr_w-1:0]    araddr;
   logic                 arvalid;
   logic                 arready;
   logic [data_w-1:0]    rdata;
   logic [1:0]           rresp;
   logic                 rvalid;
   logic                 rready;
   logic [addr_w-1:0]    m_araddr;
   logic [axi_id_w-1:0]  m_arid;
   logic [axi_len_w-1:0] m_arlen;
   logic [2:0]           m_arsize;
   logic [1:0]           m_arburst;
   logic                 m_arlock;
   logic [3:0]           m_arcache;
   logic [2:0]           m_arprot;
   logic [3:0]           m_arqos;
   logic                 m_arvalid;
   logic                 m_arready;
   logic [data_w-1:0]    m_rdata;
   logic [1:0]           m_rresp;
   logic                 m_rlast;
   logic                 m_rvalid;
   logic                 m_rready;
   int                   burst_count;
   int                   cycles = 0;
   int                   checks = 0;
   int                   errors = 0;
   int                   ar_seen = 0;
   int                   beats_seen = 0;
   logic [addr_w-1:0]    ar_addr_log  [64];
   logic [axi_len_w-1:0] ar_len_log   [64];
   logic [2:0]           ar_size_log  [64];
   logic [1:0]           ar_burst_log [64];
   logic [axi_id_w-1:0]  ar_id_log    [64];
   logic                 ar_lock_log  [64];
   logic [3:0]           ar_cache_log [64];
   logic [2:0]           ar_prot_log  [64];
   logic [3:0]           ar_qos_log   [64];

   read_cache_top i_dut (.*);

   axi_mem_model #(.err_line(err_line_addr), .seed(32'd3)) i_mem (
      .clk(clk), .reset(reset), .araddr(m_araddr), .arlen(m_arlen), .arvalid(m_arvalid),
      .arready(m_arready), .rdata(m_rdata), .rresp(m_rresp), .rlast(m_rlast),
      .rvalid(m_rvalid), .rready(m_rready), .burst_count(burst_count)
   );

   always #50 clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= timeout_cycles) begin
         $display("timeout, the cache did not finish all reads in %0d cycles", cycles);
         $display("summary: checks %0d, errors %0d, timeouts 1", checks, errors);
         $display("test failed");
         $finish;
      end
   end

   // log every memory address handshake
   always @(posedge clk) begin
      if (m_arvalid && m_arready && ar_seen < 64) begin
         ar_addr_log[ar_seen]  <= m_araddr;
         ar_len_log[ar_seen]   <= m_arlen;
         ar_size_log[ar_seen]  <= m_arsize;
         ar_burst_log[ar_seen] <= m_arburst;
         ar_id_log[ar_seen]    <= m_arid;
         ar_lock_log[ar_seen]  <= m_arlock;
         ar_cache_log[ar_seen] <= m_arcache;
         ar_prot_log[ar_seen]  <= m_arprot;
         ar_qos_log[ar_seen]   <= m_arqos;
         ar_seen               <= ar_seen + 1;
      end
   end

   // accepted memory data beats
   always @(posedge clk) begin
      if (m_rvalid && m_rready) begin
         beats_seen <= beats_seen + 1;
      end
   end

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("ERROR %s: got %h, expected %h at %0t", name, actual, expected, $time);
      end
   endtask

   // one cpu read, called 10 units after a rising edge
   task automatic run_row(input int r);
      logic [addr_w-1:0] addr;
      logic [data_w-1:0] want;
      logic [data_w-1:0] held;
      int                bursts_before;
      int                log_before;
      int                beats_before;
      int                latency;
      int                i;
      addr          = row_addr[r];
      want          = {18'd0, addr[15:2]} ^ 32'h5a5a0000;
      bursts_before = burst_count;
      log_before    = ar_seen;
      beats_before  = beats_seen;
      araddr        = addr;
      arvalid       = 1'b1;
      while (!arready) begin
         @(posedge clk);
         #10;
      end
      @(posedge clk);                                      // ar handshake edge
      #10;
      arvalid = 1'b0;
      latency = 0;
      while (!rvalid) begin
         @(posedge clk);
         #10;
         latency++;
      end
      if (row_bursts[r] == 0) begin
         check_value("hit latency", latency, 32'd2);
      end
      held = rdata;
      check_value("rdata", rdata, want);
      check_value("rresp", 32'(rresp), 32'd0);
      for (i = 0; i < row_stall[r]; i++) begin
         @(posedge clk);
         #10;
         check_value("rvalid held", 32'(rvalid), 32'd1);
         check_value("rdata held", rdata, held);
      end
      rready = 1'b1;
      @(posedge clk);
      #10;
      rready = 1'b0;
      check_value("rvalid after handshake", 32'(rvalid), 32'd0);
      check_value("burst count", burst_count - bursts_before, row_bursts[r]);
      check_value("m_ar handshakes", ar_seen - log_before, row_bursts[r]);
      check_value("m_r beats", beats_seen - beats_before, 4 * row_bursts[r]);  // 4 words a line
      for (i = log_before; i < ar_seen; i++) begin
         check_value("m_araddr", 32'(ar_addr_log[i]), 32'(addr & 16'hfff0));
         check_value("m_arlen", 32'(ar_len_log[i]), 32'd3);
         check_value("m_arsize", 32'(ar_size_log[i]), 32'd2);
         check_value("m_arburst", 32'(ar_burst_log[i]), 32'd1);   // incr
         check_value("m_arid", 32'(ar_id_log[i]), 32'd0);
         check_value("m_arlock", 32'(ar_lock_log[i]), 32'd0);
         check_value("m_arcache", 32'(ar_cache_log[i]), 32'h3);
         check_value("m_arprot", 32'(ar_prot_log[i]), 32'd0);
         check_value("m_arqos", 32'(ar_qos_log[i]), 32'd0);
      end
   endtask

   initial begin
      reset   = 1'b1;
      araddr  = '0;
      arvalid = 1'b0;
      rready  = 1'b0;
      repeat (8) @(posedge clk);
      #10 reset = 1'b0;
      check_value("arready", 32'(arready), 32'd1);
      check_value("rvalid", 32'(rvalid), 32'd0);
      check_value("m_arvalid", 32'(m_arvalid), 32'd0);
      for (int r = 0; r < n_rows; r++) begin
         run_row(r);
      end
      $display("summary: checks %0d, errors %0d, timeouts 0", checks, errors);
      if (errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule
